// File: design/bp_pkg.sv
// sizes, instruction classes and shared packed structs of the branch prediction front
package bp_pkg;

  // ----------------------------------------
  // table and fetch geometry
  // ----------------------------------------
  localparam int unsigned NR_ENTRIES      = 64;
  localparam int unsigned INSTR_PER_FETCH = 2;
  localparam int unsigned NR_ROWS         = NR_ENTRIES / INSTR_PER_FETCH;
  localparam int unsigned ROW_BITS        = 5;
  localparam int unsigned SLOT_BITS       = 1;

  // no compressed instructions, slots sit 4 bytes apart
  localparam logic [31:0] SLOT_BYTES  = 32'd4;
  localparam logic [31:0] FETCH_BYTES = 32'd8;

  // downstream buffer depth
  localparam int unsigned              CREDIT_BITS = 3;
  localparam logic [CREDIT_BITS-1:0]   CREDITS     = 3'd4;

  // rv32 major opcodes of interest
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  typedef enum logic [1:0] {
    OP_OTHER  = 2'd0,
    OP_BRANCH = 2'd1,
    OP_JAL    = 2'd2,
    OP_JALR   = 2'd3
  } opcode_e;

  // ----------------------------------------
  // pipeline payloads
  // ----------------------------------------
  typedef struct packed {
    logic                              valid;
    logic [31:0]                       pc;
    logic [INSTR_PER_FETCH-1:0][31:0]  instr;   // slot 0 at pc
  } fetch_t;

  typedef struct packed {
    opcode_e     kind;
    logic [31:0] instr;
  } slot_info_t;

  typedef struct packed {
    logic                                  valid;
    logic [31:0]                           pc;
    slot_info_t [INSTR_PER_FETCH-1:0]      slot;
  } decoded_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] cnt;
  } bht_entry_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        taken;
  } bht_update_t;

  typedef struct packed {
    logic valid;
    logic taken;
  } bht_pred_t;

  typedef struct packed {
    logic [31:0]                       pc;
    logic [31:0]                       next_pc;
    logic [SLOT_BITS-1:0]              taken_slot;
    logic                              taken;
    opcode_e [INSTR_PER_FETCH-1:0]     kind;
    logic [INSTR_PER_FETCH-1:0][31:0]  target;
  } pred_pkt_t;

endpackage

// File: design/branch_predecode.sv
// decode stage that registers an accepted fetch block and classifies each slot
`timescale 1ns/100ps

module branch_predecode (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  bp_pkg::fetch_t   fetch_i,
  input  logic             fetch_ready_i,
  output bp_pkg::decoded_t dec_o
);

  logic accept;

  logic                                               valid_q;
  logic [31:0]                                        pc_q;
  bp_pkg::slot_info_t [bp_pkg::INSTR_PER_FETCH-1:0]   slot_d;
  bp_pkg::slot_info_t [bp_pkg::INSTR_PER_FETCH-1:0]   slot_q;

  assign accept = fetch_i.valid && fetch_ready_i;

  // ----------------------------------------
  // opcode classification
  // ----------------------------------------
  always_comb begin
    for (int s = 0; s < bp_pkg::INSTR_PER_FETCH; s++) begin
      slot_d[s].instr = fetch_i.instr[s];
      case (fetch_i.instr[s][6:0])
        bp_pkg::OPC_BRANCH: slot_d[s].kind = bp_pkg::OP_BRANCH;
        bp_pkg::OPC_JAL:    slot_d[s].kind = bp_pkg::OP_JAL;
        bp_pkg::OPC_JALR:   slot_d[s].kind = bp_pkg::OP_JALR;
        default:            slot_d[s].kind = bp_pkg::OP_OTHER;
      endcase
    end
  end

  // ----------------------------------------
  // stage register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  // block payload only moves on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pc_q   <= fetch_i.pc;
      slot_q <= slot_d;
    end
  end

  assign dec_o.valid = valid_q;
  assign dec_o.pc    = pc_q;
  assign dec_o.slot  = slot_q;

  // fetch blocks are always 8-byte aligned
  a_fetch_aligned : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    accept |-> (fetch_i.pc[2:0] == 3'b000)
  ) else $error("unaligned fetch pc %h", fetch_i.pc);

endmodule

// File: design/bht.sv
// branch history table of 2-bit saturating counters with lookup, update and flush
`timescale 1ns/100ps

module bht (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              flush_i,
  input  logic                                              debug_mode_i,
  input  logic [31:0]                                       lookup_pc_i,
  input  bp_pkg::bht_update_t                               bht_update_i,
  output bp_pkg::bht_pred_t [bp_pkg::INSTR_PER_FETCH-1:0]   pred_o
);

  bp_pkg::bht_entry_t bht_q [bp_pkg::NR_ROWS-1:0][bp_pkg::INSTR_PER_FETCH-1:0];

  logic [bp_pkg::ROW_BITS-1:0]  lookup_row;
  logic [bp_pkg::ROW_BITS-1:0]  upd_row;
  logic                         upd_col;
  logic                         upd_en;
  logic [1:0]                   upd_cnt;
  bp_pkg::bht_entry_t           upd_old;
  bp_pkg::bht_entry_t           upd_new;
  logic                         any_valid;

  // row from pc[7:3], column (slot) from pc[2]
  assign lookup_row = lookup_pc_i[bp_pkg::ROW_BITS+2:3];
  assign upd_row    = bht_update_i.pc[bp_pkg::ROW_BITS+2:3];
  assign upd_col    = bht_update_i.pc[2];

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  for (genvar c = 0; c < bp_pkg::INSTR_PER_FETCH; c++) begin : gen_lookup
    assign pred_o[c].valid = bht_q[lookup_row][c].valid;
    assign pred_o[c].taken = bht_q[lookup_row][c].cnt[1];
  end

  // ----------------------------------------
  // update
  // ----------------------------------------
  // core updates are ignored while halted in debug
  assign upd_en  = bht_update_i.valid && !debug_mode_i;
  assign upd_old = bht_q[upd_row][upd_col];

  always_comb begin
    // fresh entries count from zero
    upd_cnt       = upd_old.valid ? upd_old.cnt : 2'b00;
    upd_new.valid = 1'b1;
    upd_new.cnt   = upd_cnt;
    if (bht_update_i.taken) begin
      if (upd_cnt != 2'b11) begin
        upd_new.cnt = upd_cnt + 2'b01;
      end
    end else begin
      if (upd_cnt != 2'b00) begin
        upd_new.cnt = upd_cnt - 2'b01;
      end
    end
  end

  // flush beats an update at the same edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < bp_pkg::NR_ROWS; r++) begin
        for (int c = 0; c < bp_pkg::INSTR_PER_FETCH; c++) begin
          bht_q[r][c] <= '0;
        end
      end
    end else if (flush_i) begin
      for (int r = 0; r < bp_pkg::NR_ROWS; r++) begin
        for (int c = 0; c < bp_pkg::INSTR_PER_FETCH; c++) begin
          bht_q[r][c] <= '0;
        end
      end
    end else if (upd_en) begin
      bht_q[upd_row][upd_col] <= upd_new;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  always_comb begin
    any_valid = 1'b0;
    for (int r = 0; r < bp_pkg::NR_ROWS; r++) begin
      for (int c = 0; c < bp_pkg::INSTR_PER_FETCH; c++) begin
        any_valid = any_valid | bht_q[r][c].valid;
      end
    end
  end

  // a cleared table must come up empty, even with an update racing the flush
  a_clear_empties : assert property (
    @(posedge clk_i)
    (flush_i || !rst_ni) |=> !any_valid
  ) else $error("table entry still valid after flush or reset");

endmodule

// File: design/predict_out.sv
// result stage with target computation, next pc selection, packet register and credits
`timescale 1ns/100ps

module predict_out (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  bp_pkg::decoded_t                                  dec_i,
  input  bp_pkg::bht_pred_t [bp_pkg::INSTR_PER_FETCH-1:0]   pred_i,
  input  logic                                              fetch_valid_i,
  input  logic                                              credit_return_i,
  output logic                                              fetch_ready_o,
  output logic                                              pkt_valid_o,
  output bp_pkg::pred_pkt_t                                 pkt_o
);

  logic [bp_pkg::INSTR_PER_FETCH-1:0][31:0]  slot_pc;
  logic [bp_pkg::INSTR_PER_FETCH-1:0][31:0]  target;
  logic [bp_pkg::INSTR_PER_FETCH-1:0]        slot_taken;
  logic                                      pick_taken;
  logic [bp_pkg::SLOT_BITS-1:0]              pick_slot;
  bp_pkg::pred_pkt_t                         pkt_d;
  bp_pkg::pred_pkt_t                         pkt_q;
  logic                                      pkt_valid_q;
  logic [bp_pkg::CREDIT_BITS-1:0]            credit_d;
  logic [bp_pkg::CREDIT_BITS-1:0]            credit_q;
  logic                                      accept;

  // ----------------------------------------
  // per-slot targets and taken decision
  // ----------------------------------------
  for (genvar s = 0; s < bp_pkg::INSTR_PER_FETCH; s++) begin : gen_slot
    logic [31:0] instr;
    logic [31:0] b_imm;
    logic [31:0] j_imm;

    assign instr = dec_i.slot[s].instr;
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign slot_pc[s] = dec_i.pc + (bp_pkg::SLOT_BYTES * s);

    always_comb begin
      case (dec_i.slot[s].kind)
        bp_pkg::OP_BRANCH: target[s] = slot_pc[s] + b_imm;
        bp_pkg::OP_JAL:    target[s] = slot_pc[s] + j_imm;
        default:           target[s] = '0;   // jalr is not predicted
      endcase
    end

    assign slot_taken[s] = (dec_i.slot[s].kind == bp_pkg::OP_JAL) ||
                           ((dec_i.slot[s].kind == bp_pkg::OP_BRANCH) &&
                            pred_i[s].valid && pred_i[s].taken);
  end

  // lowest taken slot wins
  always_comb begin
    pick_taken = 1'b0;
    pick_slot  = '0;
    for (int s = bp_pkg::INSTR_PER_FETCH - 1; s >= 0; s--) begin
      if (slot_taken[s]) begin
        pick_taken = 1'b1;
        pick_slot  = s[bp_pkg::SLOT_BITS-1:0];
      end
    end
  end

  always_comb begin
    pkt_d.pc         = dec_i.pc;
    pkt_d.taken      = pick_taken;
    pkt_d.taken_slot = pick_slot;
    pkt_d.next_pc    = pick_taken ? target[pick_slot] : dec_i.pc + bp_pkg::FETCH_BYTES;
    pkt_d.target     = target;
    for (int s = 0; s < bp_pkg::INSTR_PER_FETCH; s++) begin
      pkt_d.kind[s] = dec_i.slot[s].kind;
    end
  end

  // ----------------------------------------
  // packet register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pkt_valid_q <= 1'b0;
    end else begin
      pkt_valid_q <= dec_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_i.valid) begin
      pkt_q <= pkt_d;
    end
  end

  assign pkt_valid_o = pkt_valid_q;
  assign pkt_o       = pkt_q;

  // ----------------------------------------
  // credits
  // ----------------------------------------
  // a credit is reserved at acceptance and covers the block in flight
  assign accept        = fetch_valid_i && fetch_ready_o;
  assign fetch_ready_o = (credit_q != '0);

  always_comb begin
    credit_d = credit_q;
    if (accept && !credit_return_i) begin
      credit_d = credit_q - 1'b1;
    end else if (!accept && credit_return_i) begin
      credit_d = credit_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= bp_pkg::CREDITS;
    end else begin
      credit_q <= credit_d;
    end
  end

  // downstream must never hand back more than it was given
  a_credit_max : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credit_q <= bp_pkg::CREDITS
  ) else $error("credit count %0d above limit", credit_q);

  a_credit_no_wrap : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (credit_q == '0 && !credit_return_i) |=> (credit_q == '0)
  ) else $error("credit count wrapped below zero");

endmodule

// File: design/bp_top.sv
// top level joining predecode, history table and result stage
`timescale 1ns/100ps

module bp_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 debug_mode_i,
  input  bp_pkg::fetch_t       fetch_i,
  output logic                 fetch_ready_o,
  input  bp_pkg::bht_update_t  bht_update_i,
  input  logic                 credit_return_i,
  output logic                 pkt_valid_o,
  output bp_pkg::pred_pkt_t    pkt_o
);

  bp_pkg::decoded_t                                  dec;
  bp_pkg::bht_pred_t [bp_pkg::INSTR_PER_FETCH-1:0]   pred;

  // ----------------------------------------
  // stage 1, register and classify
  // ----------------------------------------
  branch_predecode u_predecode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_i       (fetch_i),
    .fetch_ready_i (fetch_ready_o),
    .dec_o         (dec)
  );

  // table looks up on the decode-stage pc
  bht u_bht (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .debug_mode_i (debug_mode_i),
    .lookup_pc_i  (dec.pc),
    .bht_update_i (bht_update_i),
    .pred_o       (pred)
  );

  // ----------------------------------------
  // stage 2, predict and send
  // ----------------------------------------
  predict_out u_predict_out (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .dec_i           (dec),
    .pred_i          (pred),
    .fetch_valid_i   (fetch_i.valid),
    .credit_return_i (credit_return_i),
    .fetch_ready_o   (fetch_ready_o),
    .pkt_valid_o     (pkt_valid_o),
    .pkt_o           (pkt_o)
  );

endmodule

// File: tests/tb_bp_top.sv
// directed testbench for the branch prediction front with counter model and timeout
`timescale 1ns/100ps

module tb_bp_top;

  // rough cycle budget per test, in order
  localparam int TEST_CYCLES = 20 + 15 + 40 + 35 + 30;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES + 50;
  localparam logic [31:0] NOP     = 32'h0000_0013;
  localparam logic [31:0] JALR_X1 = 32'h0000_8067;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  debug_mode_i;
  bp_pkg::fetch_t        fetch_i;
  logic                  fetch_ready_o;
  bp_pkg::bht_update_t   bht_update_i;
  logic                  credit_return_i = 1'b0;
  logic                  pkt_valid_o;
  bp_pkg::pred_pkt_t     pkt_o;

  integer     seed = 55878;
  int         cycle_cnt;
  int         test_err;
  int         tests_passed;
  int         tests_failed;
  logic       auto_credit;
  logic       manual_credit;
  logic       dbg;
  logic       ref_valid [bp_pkg::NR_ENTRIES];
  logic [1:0] ref_cnt   [bp_pkg::NR_ENTRIES];

  bp_top u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .debug_mode_i    (debug_mode_i),
    .fetch_i         (fetch_i),
    .fetch_ready_o   (fetch_ready_o),
    .bht_update_i    (bht_update_i),
    .credit_return_i (credit_return_i),
    .pkt_valid_o     (pkt_valid_o),
    .pkt_o           (pkt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // downstream consumer frees one slot per packet
  always @(posedge clk_i) begin
    credit_return_i <= auto_credit ? pkt_valid_o : manual_credit;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------
  // checks and reference counter model
  // ----------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("at %0t: %s", $time, msg);
      test_err++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_err == 0) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, test_err);
    end
  endtask

  task automatic model_clear();
    for (int i = 0; i < bp_pkg::NR_ENTRIES; i++) begin
      ref_valid[i] = 1'b0;
      ref_cnt[i]   = 2'd0;
    end
  endtask

  // entry index is {row, column} = pc[7:2]
  task automatic model_update(input logic [31:0] pc, input logic taken);
    logic [1:0] c;
    c = ref_valid[pc[7:2]] ? ref_cnt[pc[7:2]] : 2'd0;
    if (taken && c != 2'd3) begin
      c = c + 2'd1;
    end else if (!taken && c != 2'd0) begin
      c = c - 2'd1;
    end
    ref_valid[pc[7:2]] = 1'b1;
    ref_cnt[pc[7:2]]   = c;
  endtask

  function automatic logic predicted(input logic [31:0] pc);
    return ref_valid[pc[7:2]] && ref_cnt[pc[7:2]][1];
  endfunction

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  task automatic make_branch(output logic [31:0] word, output logic [31:0] imm);
    logic [31:0] r;
    r    = $random(seed);
    imm  = {{19{r[12]}}, r[12:1], 1'b0};
    word = {imm[12], imm[10:5], r[31:27], r[26:22], 3'b000, imm[4:1], imm[11], 7'b1100011};
  endtask

  task automatic make_jal(output logic [31:0] word, output logic [31:0] imm);
    logic [31:0] r;
    r    = $random(seed);
    imm  = {{11{r[20]}}, r[20:1], 1'b0};
    word = {imm[20], imm[10:1], imm[11], imm[19:12], r[31:27], 7'b1101111};
  endtask

  task automatic send_update(input logic [31:0] pc, input logic taken);
    @(posedge clk_i);
    bht_update_i <= {1'b1, pc, taken};
    if (!dbg) begin
      model_update(pc, taken);
    end
    @(posedge clk_i);
    bht_update_i.valid <= 1'b0;
  endtask

  task automatic set_debug(input logic v);
    @(posedge clk_i);
    debug_mode_i <= v;
    dbg = v;
  endtask

  task automatic flush_table();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    model_clear();
  endtask

  // returns just after the acceptance edge
  task automatic send_fetch(input logic [31:0] pc, input logic [31:0] w0, input logic [31:0] w1);
    @(posedge clk_i);
    fetch_i <= {1'b1, pc, w1, w0};
    @(negedge clk_i);
    check_true(fetch_ready_o, "fetch was not accepted, no credit left");
    @(posedge clk_i);
    fetch_i.valid <= 1'b0;
  endtask

  task automatic wait_pkt(output bp_pkg::pred_pkt_t got, output int lat);
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!pkt_valid_o && lat < 10);
    check_true(pkt_valid_o, "no packet arrived within 10 cycles");
    got = pkt_o;
  endtask

  task automatic check_block(input logic [31:0] pc,
                             input logic [31:0] w0, input bp_pkg::opcode_e k0,
                             input logic [31:0] i0,
                             input logic [31:0] w1, input bp_pkg::opcode_e k1,
                             input logic [31:0] i1);
    bp_pkg::pred_pkt_t got;
    bp_pkg::opcode_e   k [2];
    logic [31:0]       imm [2];
    logic [31:0]       tgt [2];
    logic              tk [2];
    logic [31:0]       spc;
    logic [31:0]       exp_next;
    int                lat;
    k[0]   = k0;
    k[1]   = k1;
    imm[0] = i0;
    imm[1] = i1;
    for (int s = 0; s < 2; s++) begin
      spc    = pc + 32'(4 * s);
      tgt[s] = (k[s] == bp_pkg::OP_BRANCH || k[s] == bp_pkg::OP_JAL) ? spc + imm[s] : 32'd0;
      tk[s]  = (k[s] == bp_pkg::OP_JAL) || (k[s] == bp_pkg::OP_BRANCH && predicted(spc));
    end
    exp_next = tk[0] ? tgt[0] : (tk[1] ? tgt[1] : pc + 32'd8);
    send_fetch(pc, w0, w1);
    wait_pkt(got, lat);
    check_val("packet latency", lat, 2);
    check_val("pkt_o.pc", got.pc, pc);
    check_val("pkt_o.next_pc", got.next_pc, exp_next);
    check_val("pkt_o.taken", got.taken, tk[0] | tk[1]);
    if (tk[0] | tk[1]) begin
      check_val("pkt_o.taken_slot", got.taken_slot, tk[0] ? 0 : 1);
    end
    for (int s = 0; s < 2; s++) begin
      check_val($sformatf("pkt_o.kind[%0d]", s), 32'(got.kind[s]), 32'(k[s]));
      check_val($sformatf("pkt_o.target[%0d]", s), got.target[s], tgt[s]);
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_reset_and_latency();
    bp_pkg::pred_pkt_t got;
    int                lat;
    int                seen;
    test_err = 0;
    seen     = 0;
    repeat (4) begin
      @(negedge clk_i);
      if (pkt_valid_o) seen++;
    end
    check_val("fetch_ready_o", fetch_ready_o, 1);
    check_val("pkt_valid_o pulses without fetch", seen, 0);
    check_block(32'h0000_0100, NOP, bp_pkg::OP_OTHER, 0, NOP, bp_pkg::OP_OTHER, 0);
    // two blocks on consecutive edges
    @(posedge clk_i);
    fetch_i <= {1'b1, 32'h0000_0108, NOP, NOP};
    @(posedge clk_i);
    fetch_i <= {1'b1, 32'h0000_0110, NOP, NOP};
    @(posedge clk_i);
    fetch_i.valid <= 1'b0;
    wait_pkt(got, lat);
    check_val("pkt_o.pc", got.pc, 32'h0000_0108);
    @(negedge clk_i);
    check_val("pkt_valid_o", pkt_valid_o, 1);
    check_val("pkt_o.pc", pkt_o.pc, 32'h0000_0110);
    end_test("reset and latency");
  endtask

  task automatic test_decode_targets();
    logic [31:0] wj, ij, wb, ib;
    test_err = 0;
    make_jal(wj, ij);
    make_branch(wb, ib);
    check_block(32'h0000_0400, wj, bp_pkg::OP_JAL, ij, wb, bp_pkg::OP_BRANCH, ib);
    make_branch(wb, ib);
    check_block(32'h0000_0408, wb, bp_pkg::OP_BRANCH, ib, JALR_X1, bp_pkg::OP_JALR, 0);
    make_jal(wj, ij);
    check_block(32'h0000_0410, NOP, bp_pkg::OP_OTHER, 0, wj, bp_pkg::OP_JAL, ij);
    end_test("decode and targets");
  endtask

  task automatic test_counter_training();
    logic [31:0] w0, i0, w1, i1;
    logic [31:0] pc;
    test_err = 0;
    pc = 32'h0000_1040;
    make_branch(w0, i0);
    make_branch(w1, i1);
    repeat (2) send_update(pc, 1'b1);
    check_block(pc, w0, bp_pkg::OP_BRANCH, i0, w1, bp_pkg::OP_BRANCH, i1);
    send_update(pc, 1'b1);
    send_update(pc, 1'b0);
    check_block(pc, w0, bp_pkg::OP_BRANCH, i0, w1, bp_pkg::OP_BRANCH, i1);
    // other column weakly taken, then drive slot 0 to the floor
    repeat (2) send_update(pc + 32'd4, 1'b1);
    repeat (4) send_update(pc, 1'b0);
    check_block(pc, w0, bp_pkg::OP_BRANCH, i0, w1, bp_pkg::OP_BRANCH, i1);
    send_update(pc, 1'b1);
    check_block(pc, w0, bp_pkg::OP_BRANCH, i0, w1, bp_pkg::OP_BRANCH, i1);
    end_test("counter training");
  endtask

  task automatic test_debug_and_flush();
    logic [31:0] w0, i0, w1, i1;
    logic [31:0] pc;
    test_err = 0;
    pc = 32'h0000_2088;
    make_branch(w0, i0);
    set_debug(1'b1);
    repeat (3) send_update(pc, 1'b1);
    set_debug(1'b0);
    check_block(pc, w0, bp_pkg::OP_BRANCH, i0, NOP, bp_pkg::OP_OTHER, 0);
    repeat (2) send_update(pc, 1'b1);
    check_block(pc, w0, bp_pkg::OP_BRANCH, i0, NOP, bp_pkg::OP_OTHER, 0);
    flush_table();
    check_block(pc, w0, bp_pkg::OP_BRANCH, i0, NOP, bp_pkg::OP_OTHER, 0);
    make_branch(w0, i0);
    make_branch(w1, i1);
    check_block(32'h0000_1040, w0, bp_pkg::OP_BRANCH, i0, w1, bp_pkg::OP_BRANCH, i1);
    end_test("debug and flush");
  endtask

  task automatic test_credit_backpressure();
    int acc;
    int pk;
    test_err = 0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    auto_credit = 1'b0;
    @(posedge clk_i);
    fetch_i <= {1'b1, 32'h0000_3000, NOP, NOP};
    acc = 0;
    pk  = 0;
    repeat (10) begin
      @(negedge clk_i);
      if (fetch_ready_o) acc++;
      if (pkt_valid_o) pk++;
    end
    check_val("accepted fetches", acc, 4);
    check_val("packets received", pk, 4);
    check_val("fetch_ready_o", fetch_ready_o, 0);
    // a single returned credit
    @(negedge clk_i);
    manual_credit = 1'b1;
    @(negedge clk_i);
    manual_credit = 1'b0;
    acc = 0;
    pk  = 0;
    repeat (6) begin
      @(negedge clk_i);
      if (fetch_ready_o) acc++;
      if (pkt_valid_o) pk++;
    end
    check_val("accepted fetches after one credit", acc, 1);
    check_val("packets after one credit", pk, 1);
    @(posedge clk_i);
    fetch_i.valid <= 1'b0;
    @(negedge clk_i);
    manual_credit = 1'b1;
    repeat (4) @(negedge clk_i);
    manual_credit = 1'b0;
    auto_credit   = 1'b1;
    repeat (2) @(negedge clk_i);
    check_val("fetch_ready_o", fetch_ready_o, 1);
    end_test("credit back-pressure");
  endtask

  initial begin
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    debug_mode_i  = 1'b0;
    fetch_i       = '0;
    bht_update_i  = '0;
    auto_credit   = 1'b1;
    manual_credit = 1'b0;
    dbg           = 1'b0;
    test_err      = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    model_clear();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset_and_latency();
    test_decode_targets();
    test_counter_training();
    test_debug_and_flush();
    test_credit_backpressure();
    $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
design/bp_pkg.sv
design/branch_predecode.sv
design/bht.sv
design/predict_out.sv
design/bp_top.sv
tests/tb_bp_top.sv

// File: Makefile
# Verilator build and run for the branch prediction front

VERILATOR ?= verilator
TOP       ?= tb_bp_top
LINT_TOP  ?= bp_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
